// File: src/wb_pkg.sv
// --------------------
// Shared widths, pipe count and buffer depth for the writeback stage
// Imported by every RTL file that needs a width or a vector type
// --------------------

package wb_pkg;

  // --------------------
  // Sizes
  // --------------------

  localparam int NUM_PIPES = 2;              // Execute pipes feeding writeback
  localparam int SEQ_BITS  = 4;              // Sequence number width
  localparam int ROB_DEPTH = 2 ** SEQ_BITS;  // One entry per sequence number

  // Pipe index needs at least one bit even with a single pipe
  localparam int PIPE_BITS = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

  localparam int PC_BITS   = 32;
  localparam int ADDR_BITS = 5;
  localparam int DATA_BITS = 32;

  // --------------------
  // Vector types
  // --------------------

  typedef logic [SEQ_BITS-1:0]  seq_num_t;   // Issue order tag
  typedef logic [PC_BITS-1:0]   pc_t;
  typedef logic [ADDR_BITS-1:0] reg_addr_t;  // Architectural register
  typedef logic [DATA_BITS-1:0] reg_data_t;
  typedef logic [PIPE_BITS-1:0] pipe_idx_t;  // Which execute pipe

endpackage

// File: src/wb_intf.sv
// --------------------
// Execute result and notification interfaces of the writeback stage
// --------------------

`timescale 1ns/1ps

// Result from one execute pipe, held until val and rdy meet
interface ex_result_if;
  import wb_pkg::*;

  logic      val;
  logic      rdy;
  pc_t       pc;
  seq_num_t  seq_num;
  reg_addr_t waddr;
  reg_data_t wdata;
  logic      wen;

  modport exe (output val, pc, seq_num, waddr, wdata, wen, input rdy);
  modport wb  (input val, pc, seq_num, waddr, wdata, wen, output rdy);
endinterface

// One-cycle pulse, used for both completion and commit
interface wb_notif_if;
  import wb_pkg::*;

  logic      val;
  seq_num_t  seq_num;
  pc_t       pc;
  reg_addr_t waddr;
  reg_data_t wdata;
  logic      wen;

  modport pub (output val, seq_num, pc, waddr, wdata, wen);
  modport sub (input val, seq_num, pc, waddr, wdata, wen);
endinterface

// File: src/seq_arb.sv
// --------------------
// Oldest-first arbiter over the execute pipes
// Age is measured from its own copy of the commit head
// --------------------

`timescale 1ns/1ps

module seq_arb (
  input  logic              clk,
  input  logic              rst,
  input  wb_pkg::seq_num_t  seq_num [wb_pkg::NUM_PIPES],
  input  logic              val     [wb_pkg::NUM_PIPES],
  output logic              gnt     [wb_pkg::NUM_PIPES],
  wb_notif_if.sub           commit
);
  import wb_pkg::*;

  seq_num_t  head;                // Next sequence number to commit
  seq_num_t  age [NUM_PIPES];
  seq_num_t  best_age;
  pipe_idx_t best_idx;
  logic      found;

  // --------------------
  // Commit point tracking
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (commit.val) begin
      head <= seq_num_t'(commit.seq_num + 1'b1);  // Wraps at ROB_DEPTH
    end
  end

  // --------------------
  // Age compare
  // --------------------

  always_comb begin
    for (int i = 0; i < NUM_PIPES; i++) begin
      age[i] = seq_num[i] - head;  // Modulo distance from the head
    end
  end

  // Strict less-than, so ties stay with the lower pipe
  always_comb begin
    found    = 1'b0;
    best_idx = '0;
    best_age = '1;
    for (int i = 0; i < NUM_PIPES; i++) begin
      if (val[i] && (!found || (age[i] < best_age))) begin
        found    = 1'b1;
        best_idx = pipe_idx_t'(i);
        best_age = age[i];
      end
    end
  end

  // One-hot grant, or none when no pipe is valid
  always_comb begin
    for (int i = 0; i < NUM_PIPES; i++) begin
      gnt[i] = found && (best_idx == pipe_idx_t'(i));
    end
  end

endmodule

// File: src/reorder_buf.sv
// --------------------
// Reorder buffer indexed by sequence number
// Entries are written in any order and leave in order from the head
// --------------------

`timescale 1ns/1ps

module reorder_buf (
  input  logic               clk,
  input  logic               rst,
  input  logic               ins_en,
  input  wb_pkg::seq_num_t   ins_idx,
  input  wb_pkg::pc_t        ins_pc,
  input  wb_pkg::reg_addr_t  ins_waddr,
  input  wb_pkg::reg_data_t  ins_wdata,
  input  logic               ins_wen,
  wb_notif_if.pub            commit
);
  import wb_pkg::*;

  // --------------------
  // Storage
  // --------------------

  logic [ROB_DEPTH-1:0] valid;       // One bit per sequence number
  seq_num_t             head;

  pc_t       ent_pc    [ROB_DEPTH];
  reg_addr_t ent_waddr [ROB_DEPTH];
  reg_data_t ent_wdata [ROB_DEPTH];
  logic      ent_wen   [ROB_DEPTH];

  logic head_valid;

  assign head_valid = valid[head];

  // Valid bits and head pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      head  <= '0;
    end else begin
      if (head_valid) begin
        valid[head] <= 1'b0;          // Freed as it commits
        head        <= head + 1'b1;
      end
      if (ins_en) begin
        valid[ins_idx] <= 1'b1;
      end
    end
  end

  // Payload only changes on insert
  always_ff @(posedge clk) begin
    if (ins_en) begin
      ent_pc[ins_idx]    <= ins_pc;
      ent_waddr[ins_idx] <= ins_waddr;
      ent_wdata[ins_idx] <= ins_wdata;
      ent_wen[ins_idx]   <= ins_wen;
    end
  end

  // --------------------
  // In-order dequeue
  // --------------------

  assign commit.val     = head_valid;
  assign commit.seq_num = head;
  assign commit.pc      = ent_pc[head];
  assign commit.waddr   = ent_waddr[head];
  assign commit.wdata   = ent_wdata[head];
  assign commit.wen     = ent_wen[head];

endmodule

// File: src/wb_commit_unit.sv
// --------------------
// Writeback and commit unit
// Grants the oldest pipe, announces completion, then commits in order
// --------------------

`timescale 1ns/1ps

module wb_commit_unit (
  input  logic         clk,
  input  logic         rst,
  ex_result_if.wb      ex [wb_pkg::NUM_PIPES],
  wb_notif_if.pub      complete,
  wb_notif_if.pub      commit
);
  import wb_pkg::*;

  // --------------------
  // Pipe unpacking
  // --------------------

  logic      ex_val     [NUM_PIPES];
  seq_num_t  ex_seq_num [NUM_PIPES];
  pc_t       ex_pc      [NUM_PIPES];
  reg_addr_t ex_waddr   [NUM_PIPES];
  reg_data_t ex_wdata   [NUM_PIPES];
  logic      ex_wen     [NUM_PIPES];
  logic      gnt        [NUM_PIPES];

  for (genvar i = 0; i < NUM_PIPES; i++) begin : g_pipe
    assign ex_val[i]     = ex[i].val;
    assign ex_seq_num[i] = ex[i].seq_num;
    assign ex_pc[i]      = ex[i].pc;
    assign ex_waddr[i]   = ex[i].waddr;
    assign ex_wdata[i]   = ex[i].wdata;
    assign ex_wen[i]     = ex[i].wen;
    assign ex[i].rdy     = gnt[i];     // Ready is the grant
  end

  // Commit view shared by the buffer and the arbiter
  wb_notif_if rob_commit ();

  seq_arb u_seq_arb (
    .clk     (clk),
    .rst     (rst),
    .seq_num (ex_seq_num),
    .val     (ex_val),
    .gnt     (gnt),
    .commit  (rob_commit)
  );

  // --------------------
  // Granted pipe select
  // --------------------

  pipe_idx_t sel_idx;
  logic      sel_val;
  logic      sel_wen;

  always_comb begin
    sel_val = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      if (gnt[i]) begin
        sel_val = 1'b1;
        sel_idx = pipe_idx_t'(i);
      end
    end
  end

  // Register zero never gets written
  assign sel_wen = ex_wen[sel_idx] && (ex_waddr[sel_idx] != '0);

  assign complete.val     = sel_val;
  assign complete.seq_num = ex_seq_num[sel_idx];
  assign complete.pc      = ex_pc[sel_idx];
  assign complete.waddr   = ex_waddr[sel_idx];
  assign complete.wdata   = ex_wdata[sel_idx];
  assign complete.wen     = sel_wen;

  // --------------------
  // Pipeline register into the buffer
  // --------------------

  logic      wb_val;
  seq_num_t  wb_seq_num;
  pc_t       wb_pc;
  reg_addr_t wb_waddr;
  reg_data_t wb_wdata;
  logic      wb_wen;

  always_ff @(posedge clk) begin
    if (rst) wb_val <= 1'b0;
    else     wb_val <= sel_val;
  end

  always_ff @(posedge clk) begin
    wb_seq_num <= ex_seq_num[sel_idx];
    wb_pc      <= ex_pc[sel_idx];
    wb_waddr   <= ex_waddr[sel_idx];
    wb_wdata   <= ex_wdata[sel_idx];
    wb_wen     <= sel_wen;          // Already masked for register zero
  end

  reorder_buf u_reorder_buf (
    .clk       (clk),
    .rst       (rst),
    .ins_en    (wb_val),
    .ins_idx   (wb_seq_num),
    .ins_pc    (wb_pc),
    .ins_waddr (wb_waddr),
    .ins_wdata (wb_wdata),
    .ins_wen   (wb_wen),
    .commit    (rob_commit)
  );

  assign commit.val     = rob_commit.val;
  assign commit.seq_num = rob_commit.seq_num;
  assign commit.pc      = rob_commit.pc;
  assign commit.waddr   = rob_commit.waddr;
  assign commit.wdata   = rob_commit.wdata;
  assign commit.wen     = rob_commit.wen;

endmodule

// File: src/wb_top.sv
// --------------------
// Top level of the writeback stage with plain ports
// Per-pipe inputs are packed arrays indexed by pipe
// --------------------

`timescale 1ns/1ps

module wb_top (
  input  logic                                      clk,
  input  logic                                      rst,
  // Execute pipes
  input  logic              [wb_pkg::NUM_PIPES-1:0] ex_val,
  output logic              [wb_pkg::NUM_PIPES-1:0] ex_rdy,
  input  wb_pkg::pc_t       [wb_pkg::NUM_PIPES-1:0] ex_pc,
  input  wb_pkg::seq_num_t  [wb_pkg::NUM_PIPES-1:0] ex_seq_num,
  input  wb_pkg::reg_addr_t [wb_pkg::NUM_PIPES-1:0] ex_waddr,
  input  wb_pkg::reg_data_t [wb_pkg::NUM_PIPES-1:0] ex_wdata,
  input  logic              [wb_pkg::NUM_PIPES-1:0] ex_wen,
  // Completion
  output logic                                      complete_val,
  output wb_pkg::seq_num_t                          complete_seq_num,
  output wb_pkg::pc_t                               complete_pc,
  output wb_pkg::reg_addr_t                         complete_waddr,
  output wb_pkg::reg_data_t                         complete_wdata,
  output logic                                      complete_wen,
  // Commit
  output logic                                      commit_val,
  output wb_pkg::seq_num_t                          commit_seq_num,
  output wb_pkg::pc_t                               commit_pc,
  output wb_pkg::reg_addr_t                         commit_waddr,
  output wb_pkg::reg_data_t                         commit_wdata,
  output logic                                      commit_wen
);
  import wb_pkg::*;

  ex_result_if ex_if [NUM_PIPES] ();
  wb_notif_if  complete_if ();
  wb_notif_if  commit_if ();

  for (genvar i = 0; i < NUM_PIPES; i++) begin : g_ex
    assign ex_if[i].val     = ex_val[i];
    assign ex_if[i].pc      = ex_pc[i];
    assign ex_if[i].seq_num = ex_seq_num[i];
    assign ex_if[i].waddr   = ex_waddr[i];
    assign ex_if[i].wdata   = ex_wdata[i];
    assign ex_if[i].wen     = ex_wen[i];
    assign ex_rdy[i]        = ex_if[i].rdy;
  end

  wb_commit_unit u_wb_commit_unit (
    .clk      (clk),
    .rst      (rst),
    .ex       (ex_if),
    .complete (complete_if),
    .commit   (commit_if)
  );

  assign complete_val     = complete_if.val;
  assign complete_seq_num = complete_if.seq_num;
  assign complete_pc      = complete_if.pc;
  assign complete_waddr   = complete_if.waddr;
  assign complete_wdata   = complete_if.wdata;
  assign complete_wen     = complete_if.wen;

  assign commit_val       = commit_if.val;
  assign commit_seq_num   = commit_if.seq_num;
  assign commit_pc        = commit_if.pc;
  assign commit_waddr     = commit_if.waddr;
  assign commit_wdata     = commit_if.wdata;
  assign commit_wen       = commit_if.wen;

endmodule

// File: testbench/tb_clkgen.sv
// --------------------
// Clock and reset for the testbench
// 8 ns clock, reset held over the first two rising edges
// --------------------

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;  // Same offset as the stimulus
  end

endmodule

// File: testbench/tb_wb_top.sv
// --------------------
// Testbench for the writeback stage
// Plays the execute pipes from a data file and checks against a reference model
// --------------------

`timescale 1ns/1ps

module tb_wb_top;
  import wb_pkg::*;

  typedef struct packed {
    logic [31:0] start;      // Earliest cycle to drive
    seq_num_t    seq_num;
    pc_t         pc;
    reg_addr_t   waddr;
    reg_data_t   wdata;
    logic        wen;
  } rec_t;

  logic clk;
  logic rst;

  logic      [NUM_PIPES-1:0] ex_val;
  logic      [NUM_PIPES-1:0] ex_rdy;
  pc_t       [NUM_PIPES-1:0] ex_pc;
  seq_num_t  [NUM_PIPES-1:0] ex_seq_num;
  reg_addr_t [NUM_PIPES-1:0] ex_waddr;
  reg_data_t [NUM_PIPES-1:0] ex_wdata;
  logic      [NUM_PIPES-1:0] ex_wen;

  logic      complete_val;
  seq_num_t  complete_seq_num;
  pc_t       complete_pc;
  reg_addr_t complete_waddr;
  reg_data_t complete_wdata;
  logic      complete_wen;
  logic      commit_val;
  seq_num_t  commit_seq_num;
  pc_t       commit_pc;
  reg_addr_t commit_waddr;
  reg_data_t commit_wdata;
  logic      commit_wen;

  // --------------------
  // Stimulus and reference model state
  // --------------------

  logic [31:0]          raw [256];            // Words straight from the data file
  rec_t                 pipe_q [NUM_PIPES][$];
  logic [NUM_PIPES-1:0] xfer;                 // Transfers seen last cycle
  seq_num_t             model_head;
  logic [ROB_DEPTH-1:0] pending;
  rec_t                 exp_rec [ROB_DEPTH];
  int                   comp_cyc [ROB_DEPTH];
  int                   cyc;
  int                   num_recs;
  int                   committed;
  int                   checks;
  int                   errors;
  logic                 started;
  logic                 loaded;
  logic                 clk_seen;

  tb_clkgen u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  wb_top u_wb_top (
    .clk              (clk),
    .rst              (rst),
    .ex_val           (ex_val),
    .ex_rdy           (ex_rdy),
    .ex_pc            (ex_pc),
    .ex_seq_num       (ex_seq_num),
    .ex_waddr         (ex_waddr),
    .ex_wdata         (ex_wdata),
    .ex_wen           (ex_wen),
    .complete_val     (complete_val),
    .complete_seq_num (complete_seq_num),
    .complete_pc      (complete_pc),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen),
    .commit_val       (commit_val),
    .commit_seq_num   (commit_seq_num),
    .commit_pc        (commit_pc),
    .commit_waddr     (commit_waddr),
    .commit_wdata     (commit_wdata),
    .commit_wen       (commit_wen)
  );

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    end
  endtask

  // Seven hex words per record with up to one cycle of start jitter
  task automatic load_records();
    logic [7:0] ri;
    pipe_idx_t  pidx;
    rec_t       r;
    raw = '{default: 32'hffff_ffff};
    $readmemh("testbench/wb_testdata.txt", raw);
    ri       = 8'd0;
    num_recs = 0;
    while (raw[ri] !== 32'hffff_ffff && ri < 8'd240) begin
      r.start   = raw[ri] + ($urandom % 2);
      pidx      = pipe_idx_t'(raw[ri + 8'd1]);
      r.seq_num = seq_num_t'(raw[ri + 8'd2]);
      r.pc      = raw[ri + 8'd3];
      r.waddr   = reg_addr_t'(raw[ri + 8'd4]);
      r.wdata   = raw[ri + 8'd5];
      r.wen     = raw[ri + 8'd6][0];
      pipe_q[pidx].push_back(r);
      num_recs++;
      ri = ri + 8'd7;
    end
  endtask

  task automatic drive_pipes();
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (xfer[p]) begin
        void'(pipe_q[p].pop_front());  // Accepted last cycle
      end
      if (pipe_q[p].size() > 0 && int'(pipe_q[p][0].start) <= cyc) begin
        ex_val[p]     = 1'b1;
        ex_seq_num[p] = pipe_q[p][0].seq_num;
        ex_pc[p]      = pipe_q[p][0].pc;
        ex_waddr[p]   = pipe_q[p][0].waddr;
        ex_wdata[p]   = pipe_q[p][0].wdata;
        ex_wen[p]     = pipe_q[p][0].wen;
      end else begin
        ex_val[p] = 1'b0;
      end
    end
  endtask

  task automatic check_quiet();
    check_val("complete_val", 32'd0, 32'(complete_val));
    check_val("commit_val", 32'd0, 32'(commit_val));
    check_val("ex_rdy", 32'd0, 32'(ex_rdy));
  endtask

  // --------------------
  // Reference model
  // --------------------

  task automatic check_cycle();
    logic [NUM_PIPES-1:0] exp_gnt;
    seq_num_t             age;
    seq_num_t             best_age;
    pipe_idx_t            gp;
    rec_t                 r;
    logic                 exp_commit;
    exp_gnt  = '0;
    best_age = '0;
    gp       = '0;
    // Smallest distance from the head wins, lower pipe on a tie
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (ex_val[p]) begin
        age = pipe_q[p][0].seq_num - model_head;
        if (exp_gnt == '0 || age < best_age) begin
          exp_gnt    = '0;
          exp_gnt[p] = 1'b1;
          best_age   = age;
          gp         = pipe_idx_t'(p);
        end
      end
    end
    check_val("ex_rdy", 32'(exp_gnt), 32'(ex_rdy));
    check_val("complete_val", 32'(exp_gnt != '0), 32'(complete_val));
    if (exp_gnt != '0) begin
      r     = pipe_q[gp][0];
      r.wen = r.wen && (r.waddr != '0);  // Register zero is never written
      check_val("complete_seq_num", 32'(r.seq_num), 32'(complete_seq_num));
      check_val("complete_pc", r.pc, complete_pc);
      check_val("complete_waddr", 32'(r.waddr), 32'(complete_waddr));
      check_val("complete_wdata", r.wdata, complete_wdata);
      check_val("complete_wen", 32'(r.wen), 32'(complete_wen));
      exp_rec[r.seq_num]  = r;
      comp_cyc[r.seq_num] = cyc;
      pending[r.seq_num]  = 1'b1;
    end

    // Head leaves two cycles after completion at the earliest
    exp_commit = pending[model_head] && (cyc >= comp_cyc[model_head] + 2);
    check_val("commit_val", 32'(exp_commit), 32'(commit_val));
    if (exp_commit && commit_val) begin
      r = exp_rec[model_head];
      check_val("commit_seq_num", 32'(model_head), 32'(commit_seq_num));
      check_val("commit_pc", r.pc, commit_pc);
      check_val("commit_waddr", 32'(r.waddr), 32'(commit_waddr));
      check_val("commit_wdata", r.wdata, commit_wdata);
      check_val("commit_wen", 32'(r.wen), 32'(commit_wen));
      pending[model_head] = 1'b0;
      model_head          = model_head + 1'b1;  // Wraps at 16
      committed++;
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d  Errors: %0d  Committed: %0d of %0d",
             checks, errors, committed, num_recs);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // --------------------
  // Processes
  // --------------------

  initial begin : main
    void'($urandom(32'h6f7d));
    ex_val     = '0;
    ex_pc      = '0;
    ex_seq_num = '0;
    ex_waddr   = '0;
    ex_wdata   = '0;
    ex_wen     = '0;
    xfer       = '0;
    pending    = '0;
    model_head = '0;
    cyc        = 0;
    committed  = 0;
    checks     = 0;
    errors     = 0;
    started    = 1'b0;
    load_records();
    loaded = 1'b1;
    wait (started === 1'b1 && committed == num_recs);
    repeat (4) @(posedge clk);  // Catch stray commits
    for (int p = 0; p < NUM_PIPES; p++) begin
      assert (pipe_q[p].size() == 0) else begin
        errors++;
        $display("Pipe %0d still holds %0d records at the end", p, pipe_q[p].size());
      end
    end
    end_run();
  end

  initial begin : edge_seen
    clk_seen = 1'b0;
    @(posedge clk);
    clk_seen = 1'b1;
  end

  initial begin : stimulus
    wait (rst === 1'b0);
    cyc     = 0;
    started = 1'b1;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      #1;
      drive_pipes();
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst === 1'b1 && clk_seen === 1'b1) begin
      check_quiet();
    end else if (started === 1'b1) begin
      if (cyc == 0) begin
        check_quiet();
      end else begin
        check_cycle();
      end
      xfer = ex_val & ex_rdy;
    end
  end

  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat (20 * num_recs + 100) @(posedge clk);
    errors++;
    $display("Timeout with %0d of %0d records committed", committed, num_recs);
    end_run();
  end

endmodule

// File: wb_top.f
src/wb_pkg.sv
src/wb_intf.sv
src/seq_arb.sv
src/reorder_buf.sv
src/wb_commit_unit.sv
src/wb_top.sv
testbench/tb_clkgen.sv
testbench/tb_wb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the writeback stage testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_wb_top \
  -f wb_top.f \
  -o tb_wb_top_sim

./obj_dir/tb_wb_top_sim | tee "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
exit 0

// File: testbench/wb_testdata.txt
// start_cycle pipe seq_num pc waddr wdata wen, all hex
// Two laps of sequence numbers so the head wraps past 15
0002 0 0 00001000 01 5a5a0000 1
0003 0 1 00001004 02 5a5a0001 1
0004 0 2 00001008 03 5a5a0002 1
0005 0 3 0000100c 04 5a5a0003 1
000a 1 5 00001014 06 5a5a0005 1
000c 0 4 00001010 05 5a5a0004 1
000e 0 7 0000101c 08 5a5a0007 1
000e 1 6 00001018 07 5a5a0006 1
0014 0 9 00001024 0a 5a5a0009 1
0014 1 8 00001020 09 5a5a0008 0
0018 0 a 00001028 00 5a5a000a 1
0018 1 b 0000102c 0c 5a5a000b 1
001c 0 d 00001034 0e 5a5a000d 1
001c 1 c 00001030 0d 5a5a000c 1
0022 0 f 0000103c 10 5a5a000f 1
0022 1 0 00002000 11 a5a50010 1
0026 0 e 00001038 0f 5a5a000e 1
0028 0 1 00002004 12 a5a50011 1
0028 1 3 0000200c 14 a5a50013 1
002a 0 2 00002008 13 a5a50012 1
002c 0 5 00002014 16 a5a50015 1
002c 1 4 00002010 15 a5a50014 1
002e 0 6 00002018 00 a5a50016 1
